/* flist.f */
+incdir+source
source/dcache_pkg.sv
source/dcache_req_decode.sv
source/dcache_way_bank.sv
source/dcache_plru.sv
source/dcache_ctrl.sv
source/dcache_resp.sv
source/dcache_top.sv
dv/wb_mem_model.sv
dv/dcache_tb.sv

/* Makefile */
# Verilator run of the data cache testbench

VERILATOR ?= verilator
TOP       ?= dcache_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= STATUS: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS PASS_MSG"

# the run passes only if the pass line shows up in the output
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* dv/dcache_tb.sv */
// drives one processor request at a time; memory words start as a fixed pattern of their address
`timescale 1ns/1ns
`include "dcache_consts.svh"

module dcache_tb import dcache_pkg::*; ();

  typedef logic [`DC_TAG_W-1:0] tag_t;
  typedef logic [`DC_IDX_W-1:0] idx_t;

  localparam int   NUM_XFER    = 210;
  localparam int   CYCLE_LIMIT = NUM_XFER * 12 + 200;
  localparam time  DRIVE_DLY   = 2;
  localparam tag_t BASE_TAG    = 25'h0_1200;

  logic clock, reset, cyc, stb, we, ack;
  logic mem_cyc, mem_stb, mem_we, mem_ack;
  logic [`DC_ADDR_W-1:0] adr, mem_adr;
  logic [63:0] dat_w, dat_r, mem_dat_w, mem_dat_r;

  logic [63:0] shadow [logic [`DC_ADDR_W-`DC_OFF_W-1:0]];
  logic [63:0] exp_data, wb_data;
  logic        read_pending = 1'b0;
  dc_addr_t    wb_addr;
  integer      seed;
  int mem_reads = 0, mem_writes = 0, cycles = 0;
  int data_errors = 0, addr_errors = 0, count_errors = 0, level_errors = 0;

  dcache_top dut0 (
    .clock(clock), .reset(reset), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
    .dat_w(dat_w), .ack(ack), .dat_r(dat_r), .mem_cyc(mem_cyc), .mem_stb(mem_stb),
    .mem_we(mem_we), .mem_adr(mem_adr), .mem_dat_w(mem_dat_w), .mem_ack(mem_ack),
    .mem_dat_r(mem_dat_r)
  );

  wb_mem_model #(.SEED(64229), .MAX_DELAY(3)) mem0 (
    .clock(clock), .reset(reset), .cyc(mem_cyc), .stb(mem_stb), .we(mem_we),
    .adr(mem_adr), .dat_w(mem_dat_w), .ack(mem_ack), .dat_r(mem_dat_r)
  );

  always #20 clock = ~clock;

  function automatic logic [63:0] init_word(input logic [`DC_ADDR_W-1:0] addr);
    return {addr, ~addr} ^ 64'h3c5a_96e1_0f7b_d248;
  endfunction

  // expected read data is the last write to the word or else its initial memory word
  function automatic logic [63:0] ref_read(input dc_addr_t addr);
    if (shadow.exists({addr.tag, addr.set_index})) begin
      return shadow[{addr.tag, addr.set_index}];
    end
    return init_word({addr.tag, addr.set_index, {`DC_OFF_W{1'b0}}});
  endfunction

  function automatic dc_addr_t make_addr(input tag_t tag, input idx_t set_index);
    dc_addr_t a;
    a.tag       = tag;
    a.set_index = set_index;
    a.offset    = '0;
    return a;
  endfunction

  task automatic check_data(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      data_errors++;
      $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input dc_addr_t got, input dc_addr_t exp);
    if (got !== exp) begin
      addr_errors++;
      $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      count_errors++;
      $display("Error at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      level_errors++;
      $display("Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_idle();
    check_bit("ack", ack, 1'b0);
    check_bit("mem_cyc", mem_cyc, 1'b0);
    check_bit("mem_stb", mem_stb, 1'b0);
  endtask

  task automatic print_summary();
    $display("Summary: %0d data, %0d address, %0d count, %0d level errors",
             data_errors, addr_errors, count_errors, level_errors);
  endtask

  // starts and ends 2 ns after a rising edge
  task automatic xfer(input logic write, input dc_addr_t addr, input logic [63:0] data);
    cyc          = 1'b1;
    stb          = 1'b1;
    we           = write;
    adr          = addr;
    dat_w        = data;
    read_pending = !write;
    if (write) begin
      shadow[{addr.tag, addr.set_index}] = data;
    end else begin
      exp_data = ref_read(addr);
    end
    @(negedge clock);
    while (!ack) @(negedge clock);
    @(posedge clock);
    #DRIVE_DLY;
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
  endtask

  // read data compare at ack
  always @(negedge clock) begin
    if (!reset && ack && read_pending) begin
      check_data("dat_r", dat_r, exp_data);
    end
  end

  // a memory transfer ends when ack is seen
  always @(negedge clock) begin
    if (!reset && mem_cyc && mem_stb && mem_ack) begin
      if (mem_we) begin
        mem_writes++;
        wb_addr = mem_adr;
        wb_data = mem_dat_w;
      end else begin
        mem_reads++;
      end
    end
  end

  always @(posedge clock) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Run stopped: not finished after %0d clock cycles", CYCLE_LIMIT);
      print_summary();
      $display("STATUS: FAIL");
      $finish;
    end
  end

  initial begin
    dc_addr_t    a;
    dc_addr_t    first_addr;
    logic [63:0] vals [5];
    int          r0, w0, rnd;
    clock = 1'b0;
    reset = 1'b1;
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
    adr   = '0;
    dat_w = '0;
    seed  = 64229;
    repeat (9) begin
      @(posedge clock);
      @(negedge clock);
      check_idle();
    end
    @(posedge clock);
    #DRIVE_DLY;
    reset = 1'b0;
    repeat (2) begin
      @(negedge clock);
      check_idle();
    end
    @(posedge clock);
    #DRIVE_DLY;

    // cold read, then a hit on the same word
    a  = make_addr(tag_t'(32'h123), idx_t'(1));
    r0 = mem_reads;
    xfer(1'b0, a, '0);
    check_count("memory reads on cold read", mem_reads - r0, 1);
    r0 = mem_reads;
    w0 = mem_writes;
    xfer(1'b0, a, '0);
    check_count("memory accesses on read hit", mem_reads - r0 + mem_writes - w0, 0);

    // write miss allocates without a refill
    a  = make_addr(tag_t'(32'h456), idx_t'(2));
    r0 = mem_reads;
    xfer(1'b1, a, 64'h0123_4567_89ab_cdef);
    xfer(1'b0, a, '0);
    check_count("memory reads after write", mem_reads - r0, 0);

    // five tags in one set evict the first
    r0 = mem_reads;
    w0 = mem_writes;
    for (int k = 0; k < 5; k++) begin
      vals[k] = {$random(seed), $random(seed)};
      a = make_addr(BASE_TAG + tag_t'(k), idx_t'(5));
      if (k == 0) begin
        first_addr = a;
      end
      xfer(1'b1, a, vals[k]);
    end
    check_count("memory writes on eviction", mem_writes - w0, 1);
    check_count("memory reads on eviction", mem_reads - r0, 0);
    check_addr("mem_adr", wb_addr, first_addr);
    check_data("mem_dat_w", wb_data, vals[0]);

    // the evicted word comes back from memory
    r0 = mem_reads;
    xfer(1'b0, first_addr, '0);
    check_count("memory reads on re-read", mem_reads - r0, 1);

    // random mix over three sets and eight tags
    for (int n = 0; n < 200; n++) begin
      rnd = $random(seed);
      a = make_addr(BASE_TAG + tag_t'($unsigned($random(seed)) % 8),
                    idx_t'(8 + $unsigned($random(seed)) % 3));
      xfer(rnd[0], a, {$random(seed), $random(seed)});
    end

    print_summary();
    if (data_errors + addr_errors + count_errors + level_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* dv/wb_mem_model.sv */
// Wishbone classic memory slave with 32-bit byte address and 64-bit words; one access at a time
`timescale 1ns/1ns

module wb_mem_model #(
  parameter int SEED      = 64229,
  parameter int MAX_DELAY = 3
) (
  input  logic        clock,
  input  logic        reset,
  input  logic        cyc,
  input  logic        stb,
  input  logic        we,
  input  logic [31:0] adr,
  input  logic [63:0] dat_w,
  output logic        ack,
  output logic [63:0] dat_r
);

  // words written so far, keyed by word address
  logic [63:0] store [logic [28:0]];
  integer      seed;
  int          wait_left;
  logic        busy;

  initial begin
    seed = SEED;
  end

  // content of a word that was never written
  function automatic logic [63:0] init_word(input logic [31:0] addr);
    return {addr, ~addr} ^ 64'h3c5a_96e1_0f7b_d248;
  endfunction

  // delay is drawn when a new access shows up
  always @(posedge clock) begin
    int delay;
    if (reset) begin
      ack       <= 1'b0;
      busy      <= 1'b0;
      wait_left <= 0;
      dat_r     <= '0;
    end else if (ack) begin
      ack <= 1'b0;
    end else if (cyc && stb) begin
      delay = busy ? wait_left : $unsigned($random(seed)) % (MAX_DELAY + 1);
      if (delay == 0) begin
        ack  <= 1'b1;
        busy <= 1'b0;
        if (we) begin
          store[adr[31:3]] = dat_w;
        end else begin
          dat_r <= store.exists(adr[31:3]) ? store[adr[31:3]] : init_word({adr[31:3], 3'b000});
        end
      end else begin
        busy      <= 1'b1;
        wait_left <= delay - 1;
      end
    end
  end

endmodule

/* source/dcache_top.sv */
// 4-way write-back data cache between two Wishbone classic ports, no byte selects
`timescale 1ns/1ns
`include "dcache_consts.svh"

module dcache_top import dcache_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,
  // processor side, slave
  input  logic                  cyc,
  input  logic                  stb,
  input  logic                  we,
  input  logic [`DC_ADDR_W-1:0] adr,
  input  logic [63:0]           dat_w,
  output logic                  ack,
  output logic [63:0]           dat_r,
  // memory side, master
  output logic                  mem_cyc,
  output logic                  mem_stb,
  output logic                  mem_we,
  output logic [`DC_ADDR_W-1:0] mem_adr,
  output logic [63:0]           mem_dat_w,
  input  logic                  mem_ack,
  input  logic [63:0]           mem_dat_r
);

  dc_req_t    req;
  logic       req_valid;
  logic       done;
  logic [3:0] hits;
  dc_line_t   way_lines [4];
  logic [3:0] way_wr_en;
  dc_line_t   wr_line;
  logic       plru_touch;
  dc_way_e    touch_way;
  dc_way_e    victim_way;
  dc_lookup_t lookup;
  logic [63:0] fill_data;

  dcache_req_decode decode0 (
    .clock     (clock),
    .reset     (reset),
    .cyc       (cyc),
    .stb       (stb),
    .we        (we),
    .adr       (adr),
    .dat_w     (dat_w),
    .done      (done),
    .req       (req),
    .req_valid (req_valid)
  );

  // all ways are read at the held request's set
  for (genvar w = 0; w < 4; w++) begin : g_way
    dcache_way_bank bank0 (
      .clock     (clock),
      .reset     (reset),
      .set_index (req.addr.set_index),
      .tag       (req.addr.tag),
      .wr_en     (way_wr_en[w]),
      .wr_line   (wr_line),
      .hit       (hits[w]),
      .line      (way_lines[w])
    );
  end

  dcache_plru plru0 (
    .clock      (clock),
    .reset      (reset),
    .set_index  (req.addr.set_index),
    .touch      (plru_touch),
    .touch_way  (touch_way),
    .victim_way (victim_way)
  );

  dcache_ctrl ctrl0 (
    .clock      (clock),
    .reset      (reset),
    .req        (req),
    .req_valid  (req_valid),
    .hits       (hits),
    .lines      (way_lines),
    .victim_way (victim_way),
    .mem_ack    (mem_ack),
    .mem_dat_r  (mem_dat_r),
    .way_wr_en  (way_wr_en),
    .wr_line    (wr_line),
    .plru_touch (plru_touch),
    .touch_way  (touch_way),
    .mem_cyc    (mem_cyc),
    .mem_stb    (mem_stb),
    .mem_we     (mem_we),
    .mem_adr    (mem_adr),
    .mem_dat_w  (mem_dat_w),
    .lookup     (lookup),
    .done       (done),
    .fill_data  (fill_data)
  );

  dcache_resp resp0 (
    .clock     (clock),
    .reset     (reset),
    .done      (done),
    .lookup    (lookup),
    .lines     (way_lines),
    .fill_data (fill_data),
    .ack       (ack),
    .dat_r     (dat_r)
  );

endmodule

/* source/dcache_resp.sv */
// result stage; ack is one cycle after done, read data valid with ack only
`timescale 1ns/1ns

module dcache_resp import dcache_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        done,
  input  dc_lookup_t  lookup,
  input  dc_line_t    lines [4],
  input  logic [63:0] fill_data,
  output logic        ack,
  output logic [63:0] dat_r
);

  always_ff @(posedge clock) begin
    if (reset) begin
      ack <= 1'b0;
    end else begin
      ack <= done;
    end
  end

  // on a miss the word comes from the refill
  always_ff @(posedge clock) begin
    if (done) begin
      dat_r <= lookup.hit ? lines[lookup.hit_way].data : fill_data;
    end
  end

  // classic Wishbone ack lasts a single cycle
  a_ack_pulse: assert property (
    @(posedge clock) disable iff (reset)
    ack |=> !ack
  );

endmodule

/* source/dcache_ctrl.sv */
// execute FSM; one request at a time, a dirty victim is written back before any refill
`timescale 1ns/1ns
`include "dcache_consts.svh"

module dcache_ctrl import dcache_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,
  input  dc_req_t               req,
  input  logic                  req_valid,
  input  logic [3:0]            hits,
  input  dc_line_t              lines [4],
  input  dc_way_e               victim_way,
  input  logic                  mem_ack,
  input  logic [63:0]           mem_dat_r,
  output logic [3:0]            way_wr_en,
  output dc_line_t              wr_line,
  output logic                  plru_touch,
  output dc_way_e               touch_way,
  output logic                  mem_cyc,
  output logic                  mem_stb,
  output logic                  mem_we,
  output logic [`DC_ADDR_W-1:0] mem_adr,
  output logic [63:0]           mem_dat_w,
  output dc_lookup_t            lookup,
  output logic                  done,
  output logic [63:0]           fill_data
);

  dc_state_e  state_q;
  dc_state_e  state_d;
  dc_lookup_t lookup_c;
  dc_way_e    hit_way_c;
  dc_addr_t   bus_addr;
  logic       is_write;

  assign is_write = (req.op == DC_OP_WRITE);

  // encode the hit vector
  always_comb begin
    hit_way_c = W0;
    for (int i = 0; i < 4; i++) begin
      if (hits[i]) begin
        hit_way_c = dc_way_e'(2'(i));
      end
    end
  end

  assign lookup_c.hit        = |hits;
  assign lookup_c.hit_way    = hit_way_c;
  assign lookup_c.victim_way = victim_way;
  assign lookup_c.victim     = lines[victim_way];

  always_comb begin
    state_d = state_q;
    case (state_q)
      // one cycle while the result goes out
      IDLE: state_d = LOOKUP;
      LOOKUP: begin
        if (req_valid) begin
          if (lookup_c.hit) begin
            state_d = DONE;
          end else if (lookup_c.victim.valid && lookup_c.victim.dirty) begin
            state_d = WB_REQ;
          end else begin
            state_d = is_write ? FILL : RF_REQ;
          end
        end
      end
      WB_REQ: begin
        if (mem_ack) begin
          state_d = is_write ? FILL : RF_REQ;
        end
      end
      RF_REQ: begin
        if (mem_ack) begin
          state_d = FILL;
        end
      end
      FILL:    state_d = DONE;
      DONE:    state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  // way writes and PLRU updates
  always_comb begin
    way_wr_en  = 4'b0000;
    plru_touch = 1'b0;
    touch_way  = W0;
    wr_line    = '{valid: 1'b1, dirty: 1'b1, tag: req.addr.tag, data: req.wdata};
    if (state_q == LOOKUP && req_valid && lookup_c.hit) begin
      plru_touch = 1'b1;
      touch_way  = hit_way_c;
      way_wr_en[hit_way_c] = is_write;
    end else if (state_q == FILL) begin
      plru_touch = 1'b1;
      touch_way  = lookup.victim_way;
      way_wr_en[lookup.victim_way] = 1'b1;
      if (!is_write) begin
        wr_line.dirty = 1'b0;
        wr_line.data  = fill_data;
      end
    end
  end

  // writeback goes to the victim's own address
  always_comb begin
    bus_addr = req.addr;
    bus_addr.offset = '0;
    if (state_q == WB_REQ) begin
      bus_addr.tag = lookup.victim.tag;
    end
  end

  assign mem_cyc   = (state_q == WB_REQ) || (state_q == RF_REQ);
  assign mem_stb   = mem_cyc;
  assign mem_we    = (state_q == WB_REQ);
  assign mem_adr   = bus_addr;
  assign mem_dat_w = lookup.victim.data;
  assign done      = (state_q == DONE);

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // lookup result stays fixed for the rest of the request
  always_ff @(posedge clock) begin
    if (state_q == LOOKUP && req_valid) begin
      lookup <= lookup_c;
    end
    if (state_q == RF_REQ && mem_ack) begin
      fill_data <= mem_dat_r;
    end
  end

  // a tag may live in one way only
  a_one_hit: assert property (
    @(posedge clock) disable iff (reset)
    req_valid |-> $onehot0(hits)
  );

  // the memory request holds still until the slave answers
  a_mem_hold: assert property (
    @(posedge clock) disable iff (reset)
    (mem_stb && !mem_ack) |=>
      (mem_cyc && mem_stb && $stable(mem_we) && $stable(mem_adr) && $stable(mem_dat_w))
  );

endmodule

/* source/dcache_plru.sv */
// tree pseudo-LRU for exactly four ways; victim is read at the current set index
`timescale 1ns/1ns
`include "dcache_consts.svh"

module dcache_plru import dcache_pkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  input  logic [`DC_IDX_W-1:0] set_index,
  input  logic                 touch,
  input  dc_way_e              touch_way,
  output dc_way_e              victim_way
);

  // root picks the pair, left covers W0/W1, right covers W2/W3
  logic [`DC_NUM_SET-1:0] root_q;
  logic [`DC_NUM_SET-1:0] left_q;
  logic [`DC_NUM_SET-1:0] right_q;

  // zero means the lower way of a pair
  always_comb begin
    if (!root_q[set_index]) begin
      victim_way = left_q[set_index] ? W1 : W0;
    end else begin
      victim_way = right_q[set_index] ? W3 : W2;
    end
  end

  // point root and the touched leaf away from the used way
  always_ff @(posedge clock) begin
    if (reset) begin
      root_q  <= '0;
      left_q  <= '0;
      right_q <= '0;
    end else if (touch) begin
      case (touch_way)
        W0: begin
          root_q[set_index] <= 1'b1;
          left_q[set_index] <= 1'b1;
        end
        W1: begin
          root_q[set_index] <= 1'b1;
          left_q[set_index] <= 1'b0;
        end
        W2: begin
          root_q[set_index]  <= 1'b0;
          right_q[set_index] <= 1'b1;
        end
        default: begin
          root_q[set_index]  <= 1'b0;
          right_q[set_index] <= 1'b0;
        end
      endcase
    end
  end

endmodule

/* source/dcache_way_bank.sv */
// one cache way of DC_NUM_SET lines; read is combinational, write takes the whole line
`timescale 1ns/1ns
`include "dcache_consts.svh"

module dcache_way_bank import dcache_pkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  input  logic [`DC_IDX_W-1:0] set_index,
  input  logic [`DC_TAG_W-1:0] tag,
  input  logic                 wr_en,
  input  dc_line_t             wr_line,
  output logic                 hit,
  output dc_line_t             line
);

  dc_line_t lines_q [`DC_NUM_SET];

  // selected line doubles as the victim candidate
  assign line = lines_q[set_index];
  assign hit  = line.valid && (line.tag == tag);

  // only the status bits are cleared, tag and data stay as they are
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int s = 0; s < `DC_NUM_SET; s++) begin
        lines_q[s].valid <= 1'b0;
        lines_q[s].dirty <= 1'b0;
      end
    end else if (wr_en) begin
      lines_q[set_index] <= wr_line;
    end
  end

endmodule

/* source/dcache_req_decode.sv */
// holds one Wishbone request until done; the master must keep stb high until ack
`timescale 1ns/1ns
`include "dcache_consts.svh"

module dcache_req_decode import dcache_pkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 cyc,
  input  logic                 stb,
  input  logic                 we,
  input  logic [`DC_ADDR_W-1:0] adr,
  input  logic [63:0]          dat_w,
  input  logic                 done,
  output dc_req_t              req,
  output logic                 req_valid
);

  logic done_q;
  logic take;

  // the master still shows the old request while ack is out,
  // so skip the cycle right after done
  assign take = cyc && stb && !req_valid && !done_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      req_valid <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      done_q <= done;
      if (req_valid && done) begin
        req_valid <= 1'b0;
      end else if (take) begin
        req_valid <= 1'b1;
      end
    end
  end

  // request payload
  always_ff @(posedge clock) begin
    if (take) begin
      req.op    <= we ? DC_OP_WRITE : DC_OP_READ;
      req.addr  <= dc_addr_t'(adr);
      req.wdata <= dat_w;
    end
  end

  // the master may not withdraw a request before ack in classic Wishbone
  a_stb_held: assert property (
    @(posedge clock) disable iff (reset)
    req_valid |-> (cyc && stb)
  );

endmodule

/* source/dcache_pkg.sv */
// shared types of the data cache; the way count is fixed at four by the tree LRU
`include "dcache_consts.svh"

package dcache_pkg;

  // address as seen by the cache with the tag on top
  typedef struct packed {
    logic [`DC_TAG_W-1:0] tag;
    logic [`DC_IDX_W-1:0] set_index;
    logic [`DC_OFF_W-1:0] offset;
  } dc_addr_t;

  // one stored line of a single 64-bit word
  typedef struct packed {
    logic                 valid;
    logic                 dirty;
    logic [`DC_TAG_W-1:0] tag;
    logic [63:0]          data;
  } dc_line_t;

  typedef enum logic {
    DC_OP_READ,
    DC_OP_WRITE
  } dc_op_e;

  // request held by the decode stage
  typedef struct packed {
    dc_op_e      op;
    dc_addr_t    addr;
    logic [63:0] wdata;
  } dc_req_t;

  typedef enum logic [1:0] {
    W0,
    W1,
    W2,
    W3
  } dc_way_e;

  // outcome of one lookup over all four ways
  typedef struct packed {
    logic     hit;
    dc_way_e  hit_way;
    dc_way_e  victim_way;
    dc_line_t victim;
  } dc_lookup_t;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    WB_REQ,
    RF_REQ,
    FILL,
    DONE
  } dc_state_e;

endpackage

/* source/dcache_consts.svh */
// geometry of the 4-way data cache; the tag width follows from the other widths
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// byte address width on both bus ports
`define DC_ADDR_W 32

// sets per way
`define DC_NUM_SET 16

// set index bits as log2 of the set count
`define DC_IDX_W 4

// byte offset bits inside one 64-bit line that the cache ignores
`define DC_OFF_W 3

// whatever is left of the address above index and offset
`define DC_TAG_W (`DC_ADDR_W - `DC_IDX_W - `DC_OFF_W)

`endif
